/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tbCore
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* compile.f */
+incdir+design
design/rvAluPkg.sv
design/pipeStage.sv
design/decodeUnit.sv
design/aluExecute.sv
design/writebackStage.sv
design/rvAluCore.sv
verif/clockGen.sv
verif/tbCore.sv

/* design/aluExecute.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvAlu_params.svh"

module aluExecute import rvAluPkg::*; (
    input  logic         clock,
    input  logic         arstN,
    input  logic         inValid,
    output logic         inReady,
    input  execPayload   inData,
    output logic         outValid,
    input  logic         outReady,
    output resultPayload outData
);

    localparam int ShiftW = $clog2(`RV_XLEN);

    logic [`RV_XLEN-1:0] opB;
    logic [ShiftW-1:0]   shamt;
    logic [`RV_XLEN-1:0] value;
    resultPayload        result;

    assign opB   = inData.useImm ? inData.imm : inData.opB;
    assign shamt = opB[ShiftW-1:0];

    always_comb begin
        case (inData.op)
            aluAdd:  value = inData.opA + opB;
            aluSub:  value = inData.opA - opB;
            aluXor:  value = inData.opA ^ opB;
            aluOr:   value = inData.opA | opB;
            aluAnd:  value = inData.opA & opB;
            aluSll:  value = inData.opA << shamt;
            aluSrl:  value = inData.opA >> shamt;
            aluSra:  value = $signed(inData.opA) >>> shamt; // Keeps sign
            default: value = '0;
        endcase
        if (inData.illegal) begin
            value = '0;
        end
    end

    always_comb begin
        result.rd      = inData.rd;
        result.write   = inData.write;
        result.illegal = inData.illegal;
        result.value   = value;
    end

    pipeStage #(.payloadT(resultPayload)) u_resultStage (
        .clock    (clock),
        .arstN    (arstN),
        .inValid  (inValid),
        .inReady  (inReady),
        .inData   (result),
        .outValid (outValid),
        .outReady (outReady),
        .outData  (outData)
    );

endmodule

`default_nettype wire

/* design/decodeUnit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvAlu_params.svh"

module decodeUnit import rvAluPkg::*; (
    input  logic                       clock,
    input  logic                       arstN,
    input  logic                       instrValid,
    output logic                       instrReady,
    input  logic [`RV_XLEN-1:0]        instr,
    output logic [`RV_REG_ADDR_W-1:0]  rs1Addr,
    output logic [`RV_REG_ADDR_W-1:0]  rs2Addr,
    input  logic [`RV_XLEN-1:0]        rs1Data,
    input  logic [`RV_XLEN-1:0]        rs2Data,
    input  logic                       exValid,
    input  logic [`RV_REG_ADDR_W-1:0]  exRd,
    input  logic                       exWrite,
    input  logic                       wbValid,
    input  logic [`RV_REG_ADDR_W-1:0]  wbRd,
    input  logic                       wbWrite,
    output logic                       stageValid,
    input  logic                       stageReady,
    output execPayload                 stageData
);

    rvOpcode                   opcode;
    logic [2:0]                funct3;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic                      isOp;
    logic                      isOpImm;
    logic                      legal;
    logic                      rs1Hit;
    logic                      rs2Hit;
    logic                      hazard;
    aluOp                      op;

    assign opcode  = rvOpcode'(instr[6:0]);
    assign funct3  = instr[14:12];
    assign rd      = instr[11:7];
    assign rs1Addr = instr[19:15];
    assign rs2Addr = instr[24:20];

    assign isOp    = (opcode == opcOp);
    assign isOpImm = (opcode == opcOpImm);
    assign legal   = isOp || isOpImm;

    ////////////////////////////////////////
    // ALU operation
    ////////////////////////////////////////
    always_comb begin
        case (funct3)
            3'b000:  op = (isOp && instr[30]) ? aluSub : aluAdd; // addi has no sub
            3'b001:  op = aluSll;
            3'b100:  op = aluXor;
            3'b101:  op = instr[30] ? aluSra : aluSrl;          // srai too
            3'b110:  op = aluOr;
            3'b111:  op = aluAnd;
            default: op = aluAdd;
        endcase
    end

    ////////////////////////////////////////
    // Hazard against both stages
    ////////////////////////////////////////
    // Write flags already exclude x0 destinations
    assign rs1Hit = legal && (rs1Addr != '0) &&
                    ((exValid && exWrite && (exRd == rs1Addr)) ||
                     (wbValid && wbWrite && (wbRd == rs1Addr)));
    assign rs2Hit = isOp && (rs2Addr != '0) &&
                    ((exValid && exWrite && (exRd == rs2Addr)) ||
                     (wbValid && wbWrite && (wbRd == rs2Addr)));
    assign hazard = rs1Hit || rs2Hit;

    assign instrReady = stageReady && !hazard;
    assign stageValid = instrValid && !hazard;

    always_comb begin
        stageData.op      = op;
        stageData.useImm  = isOpImm;
        stageData.opA     = rs1Data;
        stageData.opB     = rs2Data;
        stageData.imm     = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]}; // I-type only
        stageData.rd      = rd;
        stageData.write   = legal && (rd != '0);
        stageData.illegal = !legal;
    end

    // A stalled instruction waits unchanged on its bus
    assert property (@(posedge clock) disable iff (!arstN)
        instrValid && !instrReady |=> instrValid && $stable(instr));

endmodule

`default_nettype wire

/* design/pipeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeStage #(
    parameter type payloadT = logic
) (
    input  logic    clock,
    input  logic    arstN,
    input  logic    inValid,
    output logic    inReady,
    input  payloadT inData,
    output logic    outValid,
    input  logic    outReady,
    output payloadT outData
);

    logic    full;
    payloadT dataQ;

    // Room when empty or the held item leaves now
    assign inReady = !full || outReady;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            full <= 1'b0;
        end else if (inReady) begin
            full <= inValid;
        end
    end

    always_ff @(posedge clock) begin
        if (inValid && inReady) begin
            dataQ <= inData;
        end
    end

    assign outValid = full;
    assign outData  = dataQ;

    // Upstream keeps its offer until taken
    assert property (@(posedge clock) disable iff (!arstN)
        inValid && !inReady |=> inValid && $stable(inData));

endmodule

`default_nettype wire

/* design/rvAluCore.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvAlu_params.svh"

module rvAluCore import rvAluPkg::*; (
    input  logic                       clock,
    input  logic                       arstN,
    input  logic                       instrValid,
    output logic                       instrReady,
    input  logic [`RV_XLEN-1:0]        instr,
    input  logic                       retireReady,
    output logic                       retireValid,
    output logic [`RV_REG_ADDR_W-1:0]  retireRd,
    output logic [`RV_XLEN-1:0]        retireData,
    output logic                       retireWrite,
    output logic                       retireIllegal
);

    logic                      decValid;
    logic                      decReady;
    execPayload                decData;
    logic                      exValid;
    logic                      exReady;
    execPayload                exData;
    logic                      resValid;
    logic                      resReady;
    resultPayload              resData;
    logic [`RV_REG_ADDR_W-1:0] rs1Addr;
    logic [`RV_REG_ADDR_W-1:0] rs2Addr;
    logic [`RV_XLEN-1:0]       rs1Data;
    logic [`RV_XLEN-1:0]       rs2Data;
    logic [`RV_REG_ADDR_W-1:0] wbRd;
    logic                      wbWrite;

    decodeUnit u_decode (
        .clock (clock), .arstN (arstN),
        .instrValid (instrValid), .instrReady (instrReady), .instr (instr),
        .rs1Addr (rs1Addr), .rs2Addr (rs2Addr),
        .rs1Data (rs1Data), .rs2Data (rs2Data),
        .exValid (exValid), .exRd (exData.rd), .exWrite (exData.write),
        .wbValid (resValid), .wbRd (wbRd), .wbWrite (wbWrite),
        .stageValid (decValid), .stageReady (decReady), .stageData (decData)
    );

    // Decode to execute register
    pipeStage #(.payloadT(execPayload)) u_execStage (
        .clock (clock), .arstN (arstN),
        .inValid (decValid), .inReady (decReady), .inData (decData),
        .outValid (exValid), .outReady (exReady), .outData (exData)
    );

    aluExecute u_execute (
        .clock (clock), .arstN (arstN),
        .inValid (exValid), .inReady (exReady), .inData (exData),
        .outValid (resValid), .outReady (resReady), .outData (resData)
    );

    writebackStage u_writeback (
        .clock (clock), .arstN (arstN),
        .inValid (resValid), .inReady (resReady), .inData (resData),
        .rs1Addr (rs1Addr), .rs2Addr (rs2Addr),
        .rs1Data (rs1Data), .rs2Data (rs2Data),
        .wbRd (wbRd), .wbWrite (wbWrite),
        .retireValid (retireValid), .retireReady (retireReady),
        .retireRd (retireRd), .retireData (retireData),
        .retireWrite (retireWrite), .retireIllegal (retireIllegal)
    );

endmodule

`default_nettype wire

/* design/rvAluPkg.sv */
`default_nettype none
`include "rvAlu_params.svh"

package rvAluPkg;

    typedef enum logic [6:0] {
        opcOpImm = 7'b0010011,
        opcOp    = 7'b0110011
    } rvOpcode;

    // Encoded as {bit 30, funct3}
    typedef enum logic [3:0] {
        aluAdd = 4'b0000,
        aluSll = 4'b0001,
        aluXor = 4'b0100,
        aluSrl = 4'b0101,
        aluOr  = 4'b0110,
        aluAnd = 4'b0111,
        aluSub = 4'b1000,
        aluSra = 4'b1101
    } aluOp;

    typedef struct packed {
        aluOp                       op;
        logic                       useImm;
        logic [`RV_XLEN-1:0]        opA;
        logic [`RV_XLEN-1:0]        opB;
        logic [`RV_XLEN-1:0]        imm;
        logic [`RV_REG_ADDR_W-1:0]  rd;
        logic                       write;
        logic                       illegal;
    } execPayload;

    typedef struct packed {
        logic [`RV_REG_ADDR_W-1:0]  rd;
        logic                       write;
        logic                       illegal;
        logic [`RV_XLEN-1:0]        value;
    } resultPayload;

endpackage

`default_nettype wire

/* design/rvAlu_params.svh */
`ifndef RV_ALU_PARAMS_SVH
`define RV_ALU_PARAMS_SVH

// Datapath width
`define RV_XLEN 32

// Register index width
`define RV_REG_ADDR_W 5

// Architectural registers, x0 included
`define RV_REG_COUNT 32

`endif

/* design/writebackStage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvAlu_params.svh"

module writebackStage import rvAluPkg::*; (
    input  logic                       clock,
    input  logic                       arstN,
    input  logic                       inValid,
    output logic                       inReady,
    input  resultPayload               inData,
    input  logic [`RV_REG_ADDR_W-1:0]  rs1Addr,
    input  logic [`RV_REG_ADDR_W-1:0]  rs2Addr,
    output logic [`RV_XLEN-1:0]        rs1Data,
    output logic [`RV_XLEN-1:0]        rs2Data,
    output logic [`RV_REG_ADDR_W-1:0]  wbRd,
    output logic                       wbWrite,
    output logic                       retireValid,
    input  logic                       retireReady,
    output logic [`RV_REG_ADDR_W-1:0]  retireRd,
    output logic [`RV_XLEN-1:0]        retireData,
    output logic                       retireWrite,
    output logic                       retireIllegal
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];
    logic                doWrite;

    ////////////////////////////////////////
    // Register file
    ////////////////////////////////////////
    assign doWrite = inValid && retireReady && inData.write; // Retire transfer

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (doWrite) begin
            regs[inData.rd] <= inData.value;
        end
    end

    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

    // For the decode hazard check
    assign wbRd    = inData.rd;
    assign wbWrite = inData.write;

    assign retireValid   = inValid;
    assign inReady       = retireReady;
    assign retireRd      = inData.rd;
    assign retireData    = inData.value;
    assign retireWrite   = inData.write;
    assign retireIllegal = inData.illegal;

    // Decode must have dropped the write flag for x0
    assert property (@(posedge clock) disable iff (!arstN)
        doWrite |-> inData.rd != '0);

endmodule

`default_nettype wire

/* verif/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int halfPeriod  = 2,
    parameter int resetCycles = 16
) (
    output logic clock,
    output logic arstN
);

    initial begin
        clock = 1'b0;
        forever #halfPeriod clock = ~clock;
    end

    // Released on a falling edge, away from the flops' rising edge
    initial begin
        arstN = 1'b0;
        #(2 * halfPeriod * resetCycles) arstN = 1'b1;
    end

endmodule

`default_nettype wire

/* verif/tbCore.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rvAlu_params.svh"

module tbCore;

    localparam int timeoutCycles = 200;

    typedef struct packed {
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic                      write;
        logic                      illegal;
        logic [`RV_XLEN-1:0]       value;
    } expectT;

    logic                      clock;
    logic                      arstN;
    logic                      instrValid;
    logic                      instrReady;
    logic [`RV_XLEN-1:0]       instr;
    logic                      retireReady;
    logic                      retireValid;
    logic [`RV_REG_ADDR_W-1:0] retireRd;
    logic [`RV_XLEN-1:0]       retireData;
    logic                      retireWrite;
    logic                      retireIllegal;

    logic [`RV_XLEN-1:0] modelRegs [`RV_REG_COUNT];
    expectT              expQ [$];
    bit                  gapsOn;
    bit                  stallRetire;
    int                  acceptCount;
    int                  retireCount;
    int                  errorCount;
    int                  testErrBase;
    int                  testCount;
    // {bit 30, funct3}
    logic [3:0] rOps [8] = '{4'h0, 4'h8, 4'h1, 4'h4, 4'h5, 4'hd, 4'h6, 4'h7};
    logic [3:0] iOps [7] = '{4'h0, 4'h4, 4'h6, 4'h7, 4'h1, 4'h5, 4'hd};

    clockGen u_clockGen (.clock(clock), .arstN(arstN));

    rvAluCore u_dut (
        .clock (clock), .arstN (arstN),
        .instrValid (instrValid), .instrReady (instrReady), .instr (instr),
        .retireReady (retireReady), .retireValid (retireValid),
        .retireRd (retireRd), .retireData (retireData),
        .retireWrite (retireWrite), .retireIllegal (retireIllegal)
    );

    ////////////////////////////////////////
    // Encoders and reference model
    ////////////////////////////////////////
    function automatic logic [`RV_XLEN-1:0] encodeR(input logic alt, input logic [2:0] f3,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [`RV_XLEN-1:0] encodeI(input logic [11:0] imm,
            input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // Mostly x0..x5 so that hazards are frequent
    function automatic logic [4:0] pickReg();
        if ($urandom_range(0, 7) == 0) return 5'($urandom);
        return 5'($urandom_range(0, 5));
    endfunction

    function automatic logic [`RV_XLEN-1:0] randomLegal();
        int         pick;
        logic [3:0] sel;
        pick = int'($urandom_range(0, 14));
        if (pick < 8) begin
            sel = rOps[pick];
            return encodeR(sel[3], sel[2:0], pickReg(), pickReg(), pickReg());
        end
        sel = iOps[pick - 8];
        if (sel[1:0] == 2'b01) begin // Shift amount plus the bit-30 select
            return encodeI({1'b0, sel[3], 5'b0, 5'($urandom)}, sel[2:0], pickReg(), pickReg());
        end
        return encodeI(12'($urandom), sel[2:0], pickReg(), pickReg());
    endfunction

    function automatic expectT refExecute(input logic [`RV_XLEN-1:0] word,
            inout logic [`RV_XLEN-1:0] model [`RV_REG_COUNT]);
        expectT              res;
        logic                isReg;
        logic [`RV_XLEN-1:0] a;
        logic [`RV_XLEN-1:0] b;
        logic [4:0]          sh;
        isReg       = (word[6:0] == 7'b0110011);
        res.rd      = word[11:7];
        res.illegal = !(isReg || word[6:0] == 7'b0010011);
        res.write   = !res.illegal && (res.rd != 5'd0);
        a  = (word[19:15] == 5'd0) ? '0 : model[word[19:15]];
        b  = (word[24:20] == 5'd0) ? '0 : model[word[24:20]];
        if (!isReg) b = {{(`RV_XLEN-12){word[31]}}, word[31:20]};
        sh = b[4:0];
        case (word[14:12])
            3'b000:  res.value = (isReg && word[30]) ? a - b : a + b;
            3'b001:  res.value = a << sh;
            3'b100:  res.value = a ^ b;
            3'b101: begin
                if (word[30]) res.value = $signed(a) >>> sh;
                else res.value = a >> sh;
            end
            3'b110:  res.value = a | b;
            3'b111:  res.value = a & b;
            default: res.value = '0;
        endcase
        if (res.illegal) res.value = '0;
        if (res.write) model[res.rd] = res.value;
        return res;
    endfunction

    ////////////////////////////////////////
    // Checks and handshakes
    ////////////////////////////////////////
    task automatic checkValue(input string name, input logic [31:0] got,
            input logic [31:0] want);
        if (got !== want) begin
            $display("Mismatch %0s: got 0x%h, expected 0x%h", name, got, want);
            errorCount++;
        end
    endtask

    task automatic abortRun(input string reason);
        $display("Timeout: %0s", reason);
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic sendInstr(input logic [`RV_XLEN-1:0] word);
        int waitCount;
        if (gapsOn) begin
            repeat ($urandom_range(0, 2)) begin
                @(negedge clock);
                instrValid = 1'b0;
            end
        end
        @(negedge clock);
        instrValid = 1'b1;
        instr      = word;
        waitCount  = 0;
        #1;
        while (!instrReady && waitCount < timeoutCycles) begin
            @(negedge clock);
            #1;
            waitCount++;
        end
        if (!instrReady) abortRun("decode never accepted the instruction");
        expQ.push_back(refExecute(word, modelRegs)); // Transfer on the next rising edge
        acceptCount++;
    endtask

    task automatic drainPipe();
        int waitCount;
        waitCount = 0;
        @(negedge clock);
        instrValid = 1'b0;
        // Retire counts settle before each rising edge
        while (retireCount != acceptCount && waitCount < timeoutCycles) begin
            @(posedge clock);
            waitCount++;
        end
        if (retireCount != acceptCount) abortRun("instructions in flight never retired");
    endtask

    task automatic finishTest(input string name);
        drainPipe();
        $display("Test %0s finished with %0d errors", name, errorCount - testErrBase);
        testErrBase = errorCount;
        testCount++;
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////
    task automatic testReset();
        int waitCount;
        waitCount = 0;
        while (arstN !== 1'b1 && waitCount < timeoutCycles) begin
            @(negedge clock);
            #1;
            waitCount++;
        end
        if (arstN !== 1'b1) abortRun("reset was never released");
        checkValue("retireValid", 32'(retireValid), 32'h0);
        checkValue("instrReady", 32'(instrReady), 32'h1);
        sendInstr(encodeI(12'd5, 3'b000, 5'd1, 5'd0));
        finishTest("resetAndFirst");
    endtask

    task automatic testRType();
        for (int i = 0; i < 8; i++) begin
            for (int k = 0; k < 3; k++) begin
                sendInstr(encodeI(12'($urandom), 3'b000, 5'd6, 5'd0));
                sendInstr(encodeI(12'($urandom), 3'b100, 5'd7, 5'd6));
                sendInstr(encodeR(rOps[i][3], rOps[i][2:0], 5'd8, 5'd6, 5'd7));
            end
        end
        finishTest("rTypeOps");
    endtask

    task automatic testIType();
        logic [11:0] imm;
        logic [4:0]  shamt;
        for (int k = 0; k < 16; k++) begin
            imm     = 12'($urandom);
            imm[11] = k[0];                          // Negative source every other round
            shamt   = (k == 0) ? 5'd31 : 5'($urandom);
            sendInstr(encodeI(imm, 3'b000, 5'd9, 5'd0));
            sendInstr(encodeI(12'($urandom), iOps[k % 4][2:0], 5'd10, 5'd9));
            sendInstr(encodeI({7'b0000000, shamt}, 3'b001, 5'd11, 5'd9));
            sendInstr(encodeI({7'b0000000, shamt}, 3'b101, 5'd12, 5'd9));
            sendInstr(encodeI({7'b0100000, shamt}, 3'b101, 5'd13, 5'd9));
        end
        finishTest("iTypeOps");
    endtask

    task automatic testChains();
        logic [`RV_XLEN-1:0] word;
        logic [4:0]          prevRd;
        prevRd = 5'd1;
        for (int k = 0; k < 24; k++) begin
            word        = randomLegal();
            word[19:15] = prevRd;                    // Reads the previous result
            word[11:7]  = 5'($urandom_range(1, 5));
            prevRd      = word[11:7];
            sendInstr(word);
        end
        finishTest("dependentChains");
    endtask

    task automatic testBackPressure();
        gapsOn      = 1'b1;
        stallRetire = 1'b1;
        for (int k = 0; k < 60; k++) begin
            sendInstr(randomLegal());
        end
        drainPipe();
        @(negedge clock);
        #1;
        checkValue("retireValid", 32'(retireValid), 32'h0); // Nothing left to retire twice
        gapsOn      = 1'b0;
        stallRetire = 1'b0;
        finishTest("backPressure");
    endtask

    task automatic testIllegalX0();
        logic [6:0]          badOpc [5];
        logic [`RV_XLEN-1:0] word;
        badOpc = '{7'b0000011, 7'b0100011, 7'b1100011, 7'b1101111, 7'b0110111};
        sendInstr(encodeI(12'h123, 3'b000, 5'd1, 5'd0));
        sendInstr(encodeI(12'hffb, 3'b000, 5'd2, 5'd0));
        for (int k = 0; k < 5; k++) begin
            word       = $urandom;
            word[6:0]  = badOpc[k];
            word[11:7] = 5'(k % 2 + 1);              // Aimed at x1 and x2
            sendInstr(word);
        end
        sendInstr(encodeI(12'h7ff, 3'b000, 5'd0, 5'd1));
        sendInstr(encodeR(1'b0, 3'b000, 5'd0, 5'd1, 5'd2));
        sendInstr(encodeI(12'h0f0, 3'b100, 5'd0, 5'd2));
        // Read x1 and x2 back
        sendInstr(encodeR(1'b0, 3'b000, 5'd3, 5'd1, 5'd0));
        sendInstr(encodeR(1'b0, 3'b110, 5'd4, 5'd2, 5'd0));
        finishTest("illegalAndX0");
    endtask

    ////////////////////////////////////////
    // Retire side
    ////////////////////////////////////////
    initial begin : driveRetireReady
        retireReady = 1'b1;
        forever begin
            @(negedge clock);
            retireReady = !stallRetire || ($urandom_range(0, 2) != 0);
        end
    end

    initial begin : compareRetire
        expectT want;
        forever begin
            @(negedge clock);
            #1;
            if (arstN && retireValid && retireReady) begin
                retireCount++;
                if (expQ.size() == 0) begin
                    $display("An instruction retired that was never accepted");
                    errorCount++;
                end else begin
                    want = expQ.pop_front();
                    checkValue("retireRd", 32'(retireRd), 32'(want.rd));
                    checkValue("retireData", retireData, want.value);
                    checkValue("retireWrite", 32'(retireWrite), 32'(want.write));
                    checkValue("retireIllegal", 32'(retireIllegal), 32'(want.illegal));
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h416c08f2));
        instrValid = 1'b0;
        instr      = '0;
        for (int i = 0; i < `RV_REG_COUNT; i++) begin
            modelRegs[i] = '0;
        end
        testReset();
        testRType();
        testIType();
        testChains();
        testBackPressure();
        testIllegalX0();
        $display("Tests %0d, accepted %0d, retired %0d, errors %0d",
                 testCount, acceptCount, retireCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
